//--- common/ex_settings.svh
// Execute stage settings
`ifndef EX_SETTINGS_SVH
`define EX_SETTINGS_SVH

// Data and address width of the core
`define EX_XLEN 32

// PC increment for a full 32-bit instruction
`define EX_PC_STEP_FULL 4

// PC increment for a compressed 16-bit instruction
`define EX_PC_STEP_COMP 2

// CSR address of the security control word
`define EX_CPUCTRL_ADDR 12'hBF0

`endif

//--- common/ex_pkg.sv
// Execute stage types
`default_nettype none
`include "ex_settings.svh"

package ex_pkg;

  //////////////////////////////////////////////////
  // Operation encoding
  //////////////////////////////////////////////////

  // Plain ALU operations use the lower half of the encoding space
  // Branch conditions have bit 3 set so decode can test a single bit
  typedef enum logic [3:0] {
    ALU_ADD = 4'h0,
    ALU_SUB = 4'h1,
    ALU_AND = 4'h2,
    ALU_OR  = 4'h3,
    ALU_XOR = 4'h4,
    ALU_SLL = 4'h5,
    ALU_SRL = 4'h6,
    ALU_SLT = 4'h7,
    ALU_BEQ = 4'h8,
    ALU_BNE = 4'h9,
    ALU_BLT = 4'hA,
    ALU_BGE = 4'hB
  } alu_op_e;

  //////////////////////////////////////////////////
  // Branch helpers
  //////////////////////////////////////////////////

  // True for the four branch comparison operations
  function automatic logic is_branch_op(alu_op_e op);
    return op[3];
  endfunction

  // Resolve a branch condition from the equal and signed less-than flags
  function automatic logic branch_cond_met(alu_op_e op, logic eq, logic lt);
    case (op)
      ALU_BEQ: return eq;
      ALU_BNE: return !eq;
      ALU_BLT: return lt;
      ALU_BGE: return !lt;
      default: return 1'b0;
    endcase
  endfunction

  // Fall-through distance of a branch, which depends on its length
  function automatic logic [`EX_XLEN-1:0] pc_step(logic compressed);
    return compressed ? `EX_XLEN'(`EX_PC_STEP_COMP) : `EX_XLEN'(`EX_PC_STEP_FULL);
  endfunction

endpackage

`default_nettype wire

//--- common/xsecure_pkg.sv
// Security control types
`default_nettype none
`include "ex_settings.svh"

package xsecure_pkg;

  //////////////////////////////////////////////////
  // cpuctrl layout
  //////////////////////////////////////////////////

  // Field view of the security control word
  // Bit 0 makes branch timing independent of the operands
  // Bit 1 selects random dummy instructions, which this core only stores
  // Reserved bits keep whatever software wrote to them
  typedef struct packed {
    logic [`EX_XLEN-3:0] reserved;
    logic                rnddummy;
    logic                dataindtiming;
  } cpuctrl_fields_t;

  // The CSR instruction sees the whole word while the
  // branch logic looks at individual control bits
  typedef union packed {
    logic [`EX_XLEN-1:0] raw;
    cpuctrl_fields_t     fields;
  } cpuctrl_u;

  // Value after reset, with every protection switched off
  localparam cpuctrl_u CPUCTRL_RESET = '0;

endpackage

`default_nettype wire

//--- ex_stage/ex_alu.sv
// Execute stage ALU
`timescale 1ns/1ps
`default_nettype none
`include "ex_settings.svh"

module ex_alu
  import ex_pkg::*;
(
  input  alu_op_e             op_i,
  input  logic [`EX_XLEN-1:0] op_a_i,
  input  logic [`EX_XLEN-1:0] op_b_i,
  output logic [`EX_XLEN-1:0] result_o,
  output logic                cmp_result_o
);

  logic [`EX_XLEN-1:0] sum;
  logic [`EX_XLEN-1:0] diff;
  logic [4:0]          shamt;
  logic                eq;
  logic                lt;

  //////////////////////////////////////////////////
  // Shared arithmetic
  //////////////////////////////////////////////////

  assign sum  = op_a_i + op_b_i;
  assign diff = op_a_i - op_b_i;

  // Only the low five bits count for a 32-bit shift
  assign shamt = op_b_i[4:0];

  // Comparison flags shared by SLT and the branch conditions
  assign eq = (op_a_i == op_b_i);
  assign lt = ($signed(op_a_i) < $signed(op_b_i));

  //////////////////////////////////////////////////
  // Result mux
  //////////////////////////////////////////////////

  always_comb begin
    case (op_i)
      ALU_ADD: result_o = sum;
      ALU_SUB: result_o = diff;
      ALU_AND: result_o = op_a_i & op_b_i;
      ALU_OR:  result_o = op_a_i | op_b_i;
      ALU_XOR: result_o = op_a_i ^ op_b_i;
      ALU_SLL: result_o = op_a_i << shamt;
      ALU_SRL: result_o = op_a_i >> shamt;
      // Set on signed less-than, zero extended to full width
      ALU_SLT: result_o = {{(`EX_XLEN-1){1'b0}}, lt};
      // Branches do not write the register file, so the value is unused
      default: result_o = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // Comparison output
  //////////////////////////////////////////////////

  // The branch unit only trusts this flag for branch operations
  // SLT reports its comparison here as well
  always_comb begin
    if (is_branch_op(op_i)) begin
      cmp_result_o = branch_cond_met(op_i, eq, lt);
    end else if (op_i == ALU_SLT) begin
      cmp_result_o = lt;
    end else begin
      cmp_result_o = 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- ex_stage/ex_branch_unit.sv
// Branch decision and target
`timescale 1ns/1ps
`default_nettype none
`include "ex_settings.svh"

module ex_branch_unit
  import ex_pkg::*;
  import xsecure_pkg::*;
(
  input  logic                br_en_i,
  input  logic                cmp_result_i,
  input  logic                compressed_i,
  input  logic [`EX_XLEN-1:0] pc_i,
  input  logic [`EX_XLEN-1:0] offset_i,
  input  cpuctrl_u            cpuctrl_i,
  output logic                decision_o,
  output logic [`EX_XLEN-1:0] target_o
);

  logic                dit;
  logic                use_offset;
  logic [`EX_XLEN-1:0] taken_target;
  logic [`EX_XLEN-1:0] fall_target;

  //////////////////////////////////////////////////
  // Candidate targets
  //////////////////////////////////////////////////

  // Data independent timing bit from the security control word
  assign dit = cpuctrl_i.fields.dataindtiming;

  // Target of a taken branch
  assign taken_target = pc_i + offset_i;

  // Address of the next sequential instruction
  assign fall_target = pc_i + pc_step(compressed_i);

  //////////////////////////////////////////////////
  // Decision
  //////////////////////////////////////////////////

  // With data independent timing every branch redirects the fetch,
  // so taken and not taken branches cost the same number of cycles
  assign decision_o = br_en_i && (cmp_result_i || dit);

  // A not taken branch under that rule jumps to its own fall-through
  // address, so the redirect lands where sequential fetch would have gone
  assign use_offset = !dit || cmp_result_i;

  assign target_o = use_offset ? taken_target : fall_target;

endmodule

`default_nettype wire

//--- ex_stage/ex_stage.sv
// Execute pipeline stage
`timescale 1ns/1ps
`default_nettype none
`include "ex_settings.svh"

module ex_stage
  import ex_pkg::*;
  import xsecure_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n_i,
  input  logic                id_valid_i,
  input  alu_op_e             id_op_i,
  input  logic                id_alu_en_i,
  input  logic                id_br_en_i,
  input  logic                id_csr_en_i,
  input  logic [4:0]          id_rd_i,
  input  logic [`EX_XLEN-1:0] id_op_a_i,
  input  logic [`EX_XLEN-1:0] id_op_b_i,
  input  logic [`EX_XLEN-1:0] id_pc_i,
  input  logic [`EX_XLEN-1:0] id_br_offset_i,
  input  logic                id_compressed_i,
  input  logic [11:0]         id_csr_addr_i,
  input  logic                halt_ex_i,
  input  logic                kill_ex_i,
  input  logic                wb_ready_i,
  input  cpuctrl_u            cpuctrl_i,
  output logic                ex_ready_o,
  output logic                wb_valid_o,
  output logic [4:0]          wb_rd_o,
  output logic                wb_rf_we_o,
  output logic [`EX_XLEN-1:0] wb_result_o,
  output logic                wb_illegal_o,
  output logic                pc_set_o,
  output logic [`EX_XLEN-1:0] branch_target_o,
  output logic                csr_we_o,
  output logic [`EX_XLEN-1:0] csr_wdata_o
);

  // ID/EX register contents
  logic                instr_valid_q;
  alu_op_e             op_q;
  logic                alu_en_q;
  logic                br_en_q;
  logic                csr_en_q;
  logic [4:0]          rd_q;
  logic [`EX_XLEN-1:0] op_a_q;
  logic [`EX_XLEN-1:0] op_b_q;
  logic [`EX_XLEN-1:0] pc_q;
  logic [`EX_XLEN-1:0] offset_q;
  logic                compressed_q;
  logic [11:0]         csr_addr_q;

  logic                ex_valid;
  logic                ex_fire;
  logic                csr_illegal;
  logic [`EX_XLEN-1:0] alu_result;
  logic                cmp_result;
  logic                br_decision;
  logic [`EX_XLEN-1:0] br_target;

  //////////////////////////////////////////////////
  // Handshake
  //////////////////////////////////////////////////

  assign ex_valid = instr_valid_q && !halt_ex_i && !kill_ex_i;
  assign ex_fire  = ex_valid && wb_ready_i;

  // A CSR instruction blocks decode until it has left, which leaves
  // EX empty on the cycle after a cpuctrl write
  assign ex_ready_o = kill_ex_i ||
                      (!halt_ex_i && !(instr_valid_q && csr_en_q) &&
                       (!instr_valid_q || wb_ready_i));

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      instr_valid_q <= 1'b0;
    end else if (ex_ready_o) begin
      // Also covers kill, which drops the old instruction
      instr_valid_q <= id_valid_i;
    end else if (ex_fire) begin
      instr_valid_q <= 1'b0;
    end
  end

  // Instruction payload is only meaningful while instr_valid_q is set
  always_ff @(posedge clk) begin
    if (ex_ready_o && id_valid_i) begin
      op_q         <= id_op_i;
      alu_en_q     <= id_alu_en_i;
      br_en_q      <= id_br_en_i;
      csr_en_q     <= id_csr_en_i;
      rd_q         <= id_rd_i;
      op_a_q       <= id_op_a_i;
      op_b_q       <= id_op_b_i;
      pc_q         <= id_pc_i;
      offset_q     <= id_br_offset_i;
      compressed_q <= id_compressed_i;
      csr_addr_q   <= id_csr_addr_i;
    end
  end

  //////////////////////////////////////////////////
  // Functional units
  //////////////////////////////////////////////////

  ex_alu u_alu (
    .op_i         (op_q),
    .op_a_i       (op_a_q),
    .op_b_i       (op_b_q),
    .result_o     (alu_result),
    .cmp_result_o (cmp_result)
  );

  ex_branch_unit u_branch (
    .br_en_i      (br_en_q),
    .cmp_result_i (cmp_result),
    .compressed_i (compressed_q),
    .pc_i         (pc_q),
    .offset_i     (offset_q),
    .cpuctrl_i    (cpuctrl_i),
    .decision_o   (br_decision),
    .target_o     (br_target)
  );

  // Only cpuctrl exists, every other CSR address is illegal
  assign csr_illegal = csr_en_q && (csr_addr_q != `EX_CPUCTRL_ADDR);

  // The write lands on the same edge that hands the instruction to WB
  assign csr_we_o    = ex_fire && csr_en_q && !csr_illegal;
  assign csr_wdata_o = op_a_q;

  //////////////////////////////////////////////////
  // EX/WB register
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wb_valid_o   <= 1'b0;
      wb_rf_we_o   <= 1'b0;
      wb_illegal_o <= 1'b0;
      pc_set_o     <= 1'b0;
    end else if (ex_fire) begin
      wb_valid_o   <= 1'b1;
      wb_rf_we_o   <= alu_en_q || (csr_en_q && !csr_illegal);
      wb_illegal_o <= csr_illegal;
      pc_set_o     <= br_decision;
    end else if (wb_ready_i) begin
      // Accepted by WB with nothing behind it
      wb_valid_o   <= 1'b0;
      wb_rf_we_o   <= 1'b0;
      wb_illegal_o <= 1'b0;
      pc_set_o     <= 1'b0;
    end
  end

  // A CSR read returns the value from before its own write
  always_ff @(posedge clk) begin
    if (ex_fire) begin
      wb_rd_o         <= rd_q;
      wb_result_o     <= csr_en_q ? cpuctrl_i.raw : alu_result;
      branch_target_o <= br_target;
    end
  end

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////

  // Halt without kill freezes EX and hands nothing to write-back
  a_halt :
    assert property (@(posedge clk) disable iff (!rst_n_i)
                     (halt_ex_i && !kill_ex_i) |=>
                       ($stable(instr_valid_q) && (!wb_valid_o || $past(!wb_ready_i))))
      else $error("Halt without kill let EX move or reach write-back");

  // Kill empties EX, takes whatever decode offers and hands nothing to write-back
  a_kill :
    assert property (@(posedge clk) disable iff (!rst_n_i)
                     kill_ex_i |=>
                       ((instr_valid_q == $past(id_valid_i)) &&
                        (!wb_valid_o || $past(!wb_ready_i))))
      else $error("Kill did not empty EX or let an instruction through");

  // Decode may select at most one unit per instruction
  a_unit_onehot :
    assert property (@(posedge clk) disable iff (!rst_n_i)
                     instr_valid_q |-> $onehot0({alu_en_q, br_en_q, csr_en_q}))
      else $error("More than one functional unit enabled");

  a_illegal_csr_no_we :
    assert property (@(posedge clk) disable iff (!rst_n_i)
                     (ex_fire && csr_illegal) |=> (!wb_rf_we_o && wb_illegal_o))
      else $error("Illegal CSR instruction wrote the register file");

  // No redirect may be skipped while the timing protection is active
  a_dit_branch_taken :
    assert property (@(posedge clk) disable iff (!rst_n_i)
                     (ex_fire && br_en_q && cpuctrl_i.fields.dataindtiming) |=> pc_set_o)
      else $error("Branch not taken while dataindtiming is set");

  // The CSR hazard keeps cpuctrl fixed while anything executes
  // A write lands as its instruction leaves, so EX is empty when the new value shows
  a_cpuctrl_hazard :
    assert property (@(posedge clk) disable iff (!rst_n_i)
                     instr_valid_q |-> $stable(cpuctrl_i))
      else $error("cpuctrl changed under an instruction in EX");

endmodule

`default_nettype wire

//--- source/cpuctrl_csr.sv
// Security control register
`timescale 1ns/1ps
`default_nettype none
`include "ex_settings.svh"

module cpuctrl_csr
  import xsecure_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n_i,
  input  logic                we_i,
  input  logic [`EX_XLEN-1:0] wdata_i,
  output cpuctrl_u            cpuctrl_o
);

  cpuctrl_u cpuctrl_q;

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  // The whole word is written, reserved bits included,
  // so software reads back exactly what it stored
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cpuctrl_q <= CPUCTRL_RESET;
    end else if (we_i) begin
      cpuctrl_q.raw <= wdata_i;
    end
  end

  assign cpuctrl_o = cpuctrl_q;

  // EX is empty after every cpuctrl write, so writes never come back to back
  a_no_back_to_back_write :
    assert property (@(posedge clk) disable iff (!rst_n_i)
                     we_i |=> !we_i)
      else $error("cpuctrl written on two consecutive cycles");

endmodule

`default_nettype wire

//--- source/ex_top.sv
// Execute stage top level
`timescale 1ns/1ps
`default_nettype none
`include "ex_settings.svh"

module ex_top
  import ex_pkg::*;
  import xsecure_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n_i,
  input  logic                id_valid_i,
  input  alu_op_e             id_op_i,
  input  logic                id_alu_en_i,
  input  logic                id_br_en_i,
  input  logic                id_csr_en_i,
  input  logic [4:0]          id_rd_i,
  input  logic [`EX_XLEN-1:0] id_op_a_i,
  input  logic [`EX_XLEN-1:0] id_op_b_i,
  input  logic [`EX_XLEN-1:0] id_pc_i,
  input  logic [`EX_XLEN-1:0] id_br_offset_i,
  input  logic                id_compressed_i,
  input  logic [11:0]         id_csr_addr_i,
  input  logic                halt_ex_i,
  input  logic                kill_ex_i,
  input  logic                wb_ready_i,
  output logic                ex_ready_o,
  output logic                wb_valid_o,
  output logic [4:0]          wb_rd_o,
  output logic                wb_rf_we_o,
  output logic [`EX_XLEN-1:0] wb_result_o,
  output logic                wb_illegal_o,
  output logic                pc_set_o,
  output logic [`EX_XLEN-1:0] branch_target_o
);

  // CSR write path from the stage and the current control word back
  logic                csr_we;
  logic [`EX_XLEN-1:0] csr_wdata;
  cpuctrl_u            cpuctrl;

  ex_stage u_ex_stage (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .id_valid_i      (id_valid_i),
    .id_op_i         (id_op_i),
    .id_alu_en_i     (id_alu_en_i),
    .id_br_en_i      (id_br_en_i),
    .id_csr_en_i     (id_csr_en_i),
    .id_rd_i         (id_rd_i),
    .id_op_a_i       (id_op_a_i),
    .id_op_b_i       (id_op_b_i),
    .id_pc_i         (id_pc_i),
    .id_br_offset_i  (id_br_offset_i),
    .id_compressed_i (id_compressed_i),
    .id_csr_addr_i   (id_csr_addr_i),
    .halt_ex_i       (halt_ex_i),
    .kill_ex_i       (kill_ex_i),
    .wb_ready_i      (wb_ready_i),
    .cpuctrl_i       (cpuctrl),
    .ex_ready_o      (ex_ready_o),
    .wb_valid_o      (wb_valid_o),
    .wb_rd_o         (wb_rd_o),
    .wb_rf_we_o      (wb_rf_we_o),
    .wb_result_o     (wb_result_o),
    .wb_illegal_o    (wb_illegal_o),
    .pc_set_o        (pc_set_o),
    .branch_target_o (branch_target_o),
    .csr_we_o        (csr_we),
    .csr_wdata_o     (csr_wdata)
  );

  cpuctrl_csr u_cpuctrl_csr (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .we_i      (csr_we),
    .wdata_i   (csr_wdata),
    .cpuctrl_o (cpuctrl)
  );

endmodule

`default_nettype wire

//--- sim/tb_ex_top.sv
// Execute stage testbench
`timescale 1ns/1ps
`default_nettype none
`include "ex_settings.svh"

module tb_ex_top
  import ex_pkg::*;
();

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 10;
  localparam int HALT_CYCLES  = 3;
  localparam int MAX_REC      = 64;
  localparam int NUM_FIELDS   = 15;

  // Column positions inside one golden record
  localparam int F_TAG     = 0;
  localparam int F_OP      = 1;
  localparam int F_UNIT    = 2;
  localparam int F_RD      = 3;
  localparam int F_OP_A    = 4;
  localparam int F_OP_B    = 5;
  localparam int F_PC      = 6;
  localparam int F_OFFSET  = 7;
  localparam int F_COMP    = 8;
  localparam int F_CSR     = 9;
  localparam int F_RF_WE   = 10;
  localparam int F_RESULT  = 11;
  localparam int F_ILLEGAL = 12;
  localparam int F_PC_SET  = 13;
  localparam int F_TARGET  = 14;

  // Record tags
  localparam int TAG_KILL = 1;
  localparam int TAG_HALT = 2;

  logic                clk;
  logic                rst_n_i;
  logic                id_valid_i;
  alu_op_e             id_op_i;
  logic                id_alu_en_i;
  logic                id_br_en_i;
  logic                id_csr_en_i;
  logic [4:0]          id_rd_i;
  logic [`EX_XLEN-1:0] id_op_a_i;
  logic [`EX_XLEN-1:0] id_op_b_i;
  logic [`EX_XLEN-1:0] id_pc_i;
  logic [`EX_XLEN-1:0] id_br_offset_i;
  logic                id_compressed_i;
  logic [11:0]         id_csr_addr_i;
  logic                halt_ex_i;
  logic                kill_ex_i;
  logic                wb_ready_i;
  logic                ex_ready_o;
  logic                wb_valid_o;
  logic [4:0]          wb_rd_o;
  logic                wb_rf_we_o;
  logic [`EX_XLEN-1:0] wb_result_o;
  logic                wb_illegal_o;
  logic                pc_set_o;
  logic [`EX_XLEN-1:0] branch_target_o;

  logic [31:0] gold_mem [0:MAX_REC*NUM_FIELDS-1];
  logic [31:0] lfsr;
  int          num_rec;
  int          n_expect;
  int          checked;
  longint      limit_ns;
  bit          failed;
  int          exp_q [$];

  ex_top dut (.*);

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] field(int idx, int col);
    return gold_mem[idx*NUM_FIELDS + col];
  endfunction

  // Galois form, right shifting with taps 32, 22, 2 and 1
  function automatic logic [31:0] step_lfsr(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic string op_name(int idx);
    logic [31:0] w;
    alu_op_e     op;
    w  = field(idx, F_OP);
    op = alu_op_e'(w[3:0]);
    return op.name();
  endfunction

  task automatic stop_with_failure(string msg);
    failed = 1'b1;
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
    if (!failed) begin
      assert (act === exp)
        else stop_with_failure($sformatf("CHECK FAILED %s expected %h actual %h",
                                         name, exp, act));
    end
  endtask

  task automatic load_golden();
    // Unused slots hold the inverted address, which no tag can match
    for (int k = 0; k < MAX_REC*NUM_FIELDS; k++) begin
      gold_mem[k] = ~32'(k);
    end
    $readmemh("sim/ex_golden.txt", gold_mem);
    num_rec  = 0;
    n_expect = 0;
    // A tag still holding the fill pattern marks the first unused slot
    while (num_rec < MAX_REC &&
           gold_mem[num_rec*NUM_FIELDS] !== ~32'(num_rec*NUM_FIELDS)) begin
      if (field(num_rec, F_TAG) != TAG_KILL) begin
        n_expect++;
      end
      num_rec++;
    end
    if (num_rec == 0) begin
      stop_with_failure("The golden file holds no instruction records");
    end
  endtask

  //////////////////////////////////////////////////
  // Decode side driver
  //////////////////////////////////////////////////

  task automatic present_record(int idx);
    logic [31:0] op_w;
    logic [31:0] unit_w;
    op_w            = field(idx, F_OP);
    unit_w          = field(idx, F_UNIT);
    id_valid_i      = 1'b1;
    id_op_i         = alu_op_e'(op_w[3:0]);
    id_alu_en_i     = unit_w[0];
    id_br_en_i      = unit_w[1];
    id_csr_en_i     = unit_w[2];
    id_rd_i         = 5'(field(idx, F_RD));
    id_op_a_i       = field(idx, F_OP_A);
    id_op_b_i       = field(idx, F_OP_B);
    id_pc_i         = field(idx, F_PC);
    id_br_offset_i  = field(idx, F_OFFSET);
    id_compressed_i = 1'(field(idx, F_COMP));
    id_csr_addr_i   = 12'(field(idx, F_CSR));
  endtask

  // Returns 2 ns after the edge that moved the instruction into EX
  task automatic wait_accept();
    logic taken;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = ex_ready_o;
      @(posedge clk);
      #2;
    end
  endtask

  task automatic drive_all();
    for (int i = 0; i < num_rec; i++) begin
      present_record(i);
      wait_accept();
      if (field(i, F_TAG) == TAG_KILL) begin
        // Dropped from EX before it can reach write-back
        id_valid_i = 1'b0;
        kill_ex_i  = 1'b1;
        @(posedge clk);
        #2;
        kill_ex_i = 1'b0;
      end else begin
        exp_q.push_back(i);
        if (field(i, F_TAG) == TAG_HALT) begin
          id_valid_i = 1'b0;
          halt_ex_i  = 1'b1;
          repeat (HALT_CYCLES) @(posedge clk);
          #2;
          halt_ex_i = 1'b0;
        end
      end
    end
    id_valid_i = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Write-back monitor
  //////////////////////////////////////////////////

  task automatic check_transfer();
    int    idx;
    string name;
    if (exp_q.size() == 0) begin
      stop_with_failure("Write-back delivered a result with no instruction pending");
    end else begin
      idx  = exp_q.pop_front();
      name = $sformatf("rec%0d_%s", idx, op_name(idx));
      check_value({name, " wb_rd"}, field(idx, F_RD), 32'(wb_rd_o));
      check_value({name, " rf_we"}, field(idx, F_RF_WE), 32'(wb_rf_we_o));
      // Result only matters when the register file is written
      if (field(idx, F_RF_WE) != 0) begin
        check_value({name, " result"}, field(idx, F_RESULT), wb_result_o);
      end
      check_value({name, " illegal"}, field(idx, F_ILLEGAL), 32'(wb_illegal_o));
      check_value({name, " pc_set"}, field(idx, F_PC_SET), 32'(pc_set_o));
      if (field(idx, F_PC_SET) != 0) begin
        check_value({name, " target"}, field(idx, F_TARGET), branch_target_o);
      end
      checked++;
    end
  endtask

  // A transfer happens on the next rising edge, so sample at the falling one
  always @(negedge clk) begin
    if (rst_n_i && wb_valid_o && wb_ready_i) begin
      check_transfer();
    end
  end

  //////////////////////////////////////////////////
  // Clock, back-pressure and watchdog
  //////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // One LFSR step per cycle, its low bit is the write-back ready
  initial begin
    lfsr = 32'h16;
    forever begin
      @(posedge clk);
      #2;
      lfsr       = step_lfsr(lfsr);
      wb_ready_i = lfsr[0];
    end
  end

  initial begin
    wait (num_rec > 0);
    limit_ns = longint'(num_rec) * 40 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;
    #(limit_ns);
    stop_with_failure("Watchdog expired because the run did not finish in time");
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    rst_n_i         = 1'b0;
    id_valid_i      = 1'b0;
    id_op_i         = ALU_ADD;
    id_alu_en_i     = 1'b0;
    id_br_en_i      = 1'b0;
    id_csr_en_i     = 1'b0;
    id_rd_i         = '0;
    id_op_a_i       = '0;
    id_op_b_i       = '0;
    id_pc_i         = '0;
    id_br_offset_i  = '0;
    id_compressed_i = 1'b0;
    id_csr_addr_i   = '0;
    halt_ex_i       = 1'b0;
    kill_ex_i       = 1'b0;
    wb_ready_i      = 1'b0;
    checked         = 0;
    failed          = 1'b0;
    load_golden();
    repeat (RESET_CYCLES - 1) @(posedge clk);
    @(negedge clk);
    check_value("reset ex_ready", 32'd1, 32'(ex_ready_o));
    check_value("reset wb_valid", 32'd0, 32'(wb_valid_o));
    check_value("reset pc_set", 32'd0, 32'(pc_set_o));
    check_value("reset rf_we", 32'd0, 32'(wb_rf_we_o));
    @(posedge clk);
    #2;
    rst_n_i = 1'b1;
    drive_all();
    wait (checked == n_expect);
    // Leave room for any stray result to show up
    repeat (5) @(posedge clk);
    if (!failed && checked == n_expect && exp_q.size() == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      stop_with_failure("Write-back results do not match the instruction stream");
    end
  end

endmodule

`default_nettype wire

//--- sim/ex_golden.txt
// tag(0 run 1 kill 2 halt) op unit(1 alu 2 br 4 csr) rd op_a op_b pc offset compressed csr
// expected: rf_we result illegal pc_set target
0 0 1 01 00000005 00000007 00000100 00000000 0 000 1 0000000C 0 0 00000000
0 1 1 02 00000003 00000005 00000104 00000000 0 000 1 FFFFFFFE 0 0 00000000
0 2 1 03 F0F0F0F0 0FF00FF0 00000108 00000000 0 000 1 00F000F0 0 0 00000000
0 3 1 04 12340000 00005678 0000010C 00000000 0 000 1 12345678 0 0 00000000
0 4 1 05 FFFF0000 0F0F0F0F 00000110 00000000 0 000 1 F0F00F0F 0 0 00000000
0 5 1 06 00000001 0000001F 00000114 00000000 0 000 1 80000000 0 0 00000000
0 5 1 07 00000003 00000024 00000118 00000000 0 000 1 00000030 0 0 00000000
0 6 1 08 80000000 00000004 0000011C 00000000 0 000 1 08000000 0 0 00000000
0 7 1 09 FFFFFFFF 00000001 00000120 00000000 0 000 1 00000001 0 0 00000000
0 7 1 0A 00000005 00000002 00000124 00000000 0 000 1 00000000 0 0 00000000
0 0 1 0B FFFFFFFF 00000002 00000128 00000000 0 000 1 00000001 0 0 00000000
0 8 2 00 00000010 00000010 00000200 00000040 0 000 0 00000000 0 1 00000240
0 8 2 00 00000001 00000002 00000204 00000040 0 000 0 00000000 0 0 00000000
0 9 2 00 00000001 00000002 00000208 FFFFFFF0 0 000 0 00000000 0 1 000001F8
0 A 2 00 FFFFFFF0 00000001 0000020C 00000020 0 000 0 00000000 0 1 0000022C
0 B 2 00 FFFFFFF0 00000001 00000210 00000020 0 000 0 00000000 0 0 00000000
0 B 2 00 00000005 00000005 00000214 00000100 0 000 0 00000000 0 1 00000314
0 0 4 0C FFFFFFFF 00000000 00000300 00000000 0 300 0 00000000 1 0 00000000
0 0 4 0D 00000000 00000000 00000304 00000000 0 BF0 1 00000000 0 0 00000000
0 0 4 0E A5A50001 00000000 00000308 00000000 0 BF0 1 00000000 0 0 00000000
0 8 2 00 00000001 00000002 00000400 00000080 0 000 0 00000000 0 1 00000404
0 8 2 00 00000001 00000002 00000410 00000080 1 000 0 00000000 0 1 00000412
0 9 2 00 00000001 00000002 00000420 00000010 0 000 0 00000000 0 1 00000430
0 A 2 00 00000005 00000003 00000430 00000020 1 000 0 00000000 0 1 00000432
0 B 2 00 00000003 FFFFFFFF 00000440 FFFFFF00 0 000 0 00000000 0 1 00000340
0 0 1 10 00000100 00000200 00000444 00000000 0 000 1 00000300 0 0 00000000
1 0 1 1F DEAD0000 0000BEEF 00000448 00000000 0 000 1 DEADBEEF 0 0 00000000
0 4 1 11 0000FFFF FFFFFFFF 0000044C 00000000 0 000 1 FFFF0000 0 0 00000000
1 8 2 00 00000000 00000000 00000500 00000100 0 000 0 00000000 0 1 00000600
0 0 1 12 00000007 00000008 00000504 00000000 0 000 1 0000000F 0 0 00000000
2 1 1 13 00000064 00000014 00000508 00000000 0 000 1 00000050 0 0 00000000
2 9 2 00 00000000 00000000 00000600 00000040 0 000 0 00000000 0 1 00000604
0 0 4 14 00000002 00000000 00000604 00000000 0 BF0 1 A5A50001 0 0 00000000
0 0 4 15 FFFFFFFF 00000000 00000608 00000000 0 BF1 0 00000000 1 0 00000000
0 0 4 16 00000000 00000000 0000060C 00000000 0 BF0 1 00000002 0 0 00000000
0 8 2 00 00000001 00000000 00000700 00000010 0 000 0 00000000 0 0 00000000
2 6 1 17 FFFFFFFF 0000001C 00000704 00000000 0 000 1 0000000F 0 0 00000000
0 A 2 00 80000000 00000000 00000800 00000008 1 000 0 00000000 0 1 00000808

//--- project.f
+incdir+common
common/ex_pkg.sv
common/xsecure_pkg.sv
ex_stage/ex_alu.sv
ex_stage/ex_branch_unit.sv
ex_stage/ex_stage.sv
source/cpuctrl_csr.sv
source/ex_top.sv
sim/tb_ex_top.sv
